// File: design/daqDefines.svh
`ifndef DAQ_DEFINES_SVH
`define DAQ_DEFINES_SVH

// Threshold DAC code width
`define DAC_WIDTH 10

// Command and data words
`define WORD_WIDTH 16

// Trigger count width, saturating
`define CNT_WIDTH 16

// Result FIFO depth in words
`define FIFO_DEPTH 16

// Address field of a command word
`define REG_ADDR_WIDTH 4

// Shortest count window in clock cycles, also the reset value
`define WINDOW_MIN 16

`endif

// File: design/daqPkg.sv
`default_nettype none
`include "daqDefines.svh"

package daqPkg;

    typedef logic [`DAC_WIDTH-1:0] dacCodeT;    // One threshold DAC code
    typedef logic [`WORD_WIDTH-1:0] dataWordT;  // Word in or out of a FIFO

    // Address field, top bits of every command word
    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        DAC0       = 0,
        DAC1       = 1,
        DAC2       = 2,
        START_DAC  = 3,
        END_DAC    = 4,
        WINDOW     = 5,
        DAC_SELECT = 6,
        ACTION     = 15
    } regAddrE;

    typedef enum logic [3:0] {
        SWEEP_START = 1,
        SWEEP_STOP  = 2
    } opcodeE;

    typedef struct packed {
        regAddrE addr;
        logic [`WORD_WIDTH-`REG_ADDR_WIDTH-`DAC_WIDTH-1:0] rsvd;
        dacCodeT value;
    } regWriteT;

    typedef struct packed {
        regAddrE addr;  // ACTION here
        opcodeE opcode;
        logic [`WORD_WIDTH-`REG_ADDR_WIDTH-5:0] rsvd;
    } actionT;

    // Same 16 bits seen as a register write or as an action
    typedef union packed {
        regWriteT wr;
        actionT act;
    } cmdWordU;

endpackage

`default_nettype wire

// File: design/sweepCfgIf.sv
`timescale 1ns/100ps
`default_nettype none

interface sweepCfgIf import daqPkg::*; ();

    dacCodeT startDac;   // First code of the sweep
    dacCodeT endDac;     // Last code, inclusive
    dacCodeT window;     // Count window in cycles
    logic [1:0] dacSel;  // 3 means nothing swept
    logic start;         // One-cycle pulse
    logic stop;          // One-cycle pulse
    logic busy;          // Driven back by the controller

    // Interpreter side
    modport cfg (
        output startDac, endDac, window, dacSel, start, stop
    );

    // Controller side
    modport ctrl (
        input startDac, endDac, window, dacSel, start, stop,
        output busy
    );

endinterface

`default_nettype wire

// File: design/commandInterpreter.sv
`timescale 1ns/100ps
`default_nettype none
`include "daqDefines.svh"

module commandInterpreter import daqPkg::*; (
    input wire Clk,
    input wire rstN,
    input wire cmdEmpty,
    output logic cmdRdEn,
    input wire cmdWordU cmdWord,
    sweepCfgIf.cfg cfg,
    output dacCodeT dac0Reg,
    output dacCodeT dac1Reg,
    output dacCodeT dac2Reg
);

    logic wordValid;     // cmdWord holds a fresh word
    dacCodeT windowVal;  // Window after the lower clamp

    assign windowVal = (cmdWord.wr.value < dacCodeT'(`WINDOW_MIN)) ?
                       dacCodeT'(`WINDOW_MIN) : cmdWord.wr.value;

    //////////////////////////////////////////////////////////////////////
    // Read pacing
    // At most one read every other cycle, so cmdEmpty has settled
    // after the previous pop before the next read is issued
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            cmdRdEn <= 1'b0;
            wordValid <= 1'b0;
        end else begin
            cmdRdEn <= ~cmdEmpty & ~cmdRdEn;
            wordValid <= cmdRdEn;  // One-cycle read latency
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Decode and setting registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            dac0Reg <= '0;
            dac1Reg <= '0;
            dac2Reg <= '0;
            cfg.startDac <= '0;
            cfg.endDac <= '0;
            cfg.window <= dacCodeT'(`WINDOW_MIN);
            cfg.dacSel <= 2'd0;
            cfg.start <= 1'b0;
            cfg.stop <= 1'b0;
        end else begin
            cfg.start <= 1'b0;  // Pulses last one cycle
            cfg.stop <= 1'b0;
            if (wordValid) begin
                if (cmdWord.act.addr == ACTION) begin
                    case (cmdWord.act.opcode)
                        SWEEP_START: cfg.start <= 1'b1;
                        SWEEP_STOP:  cfg.stop <= 1'b1;
                        default: ;  // Unknown opcode dropped
                    endcase
                end else begin
                    case (cmdWord.wr.addr)
                        DAC0:       dac0Reg <= cmdWord.wr.value;
                        DAC1:       dac1Reg <= cmdWord.wr.value;
                        DAC2:       dac2Reg <= cmdWord.wr.value;
                        START_DAC:  cfg.startDac <= cmdWord.wr.value;
                        END_DAC:    cfg.endDac <= cmdWord.wr.value;
                        WINDOW:     cfg.window <= windowVal;
                        DAC_SELECT: cfg.dacSel <= cmdWord.wr.value[1:0];
                        default: ;  // Unknown address dropped
                    endcase
                end
            end
        end
    end

    // Registered read enable must only rise over a non-empty FIFO
    assert property (@(posedge Clk) disable iff (!rstN) $rose(cmdRdEn) |-> !cmdEmpty)
        else $error("cmdRdEn rose while command FIFO empty");

endmodule

`default_nettype wire

// File: design/sweepController.sv
`timescale 1ns/100ps
`default_nettype none
`include "daqDefines.svh"

module sweepController import daqPkg::*; (
    input wire Clk,
    input wire rstN,
    sweepCfgIf.ctrl cfg,
    input wire dacCodeT dac0Reg,
    input wire dacCodeT dac1Reg,
    input wire dacCodeT dac2Reg,
    input wire outTrigN,
    output dacCodeT dac0Out,
    output dacCodeT dac1Out,
    output dacCodeT dac2Out,
    output logic sweepDone,
    output logic wrEn,
    output dataWordT wrData,
    input wire full
);

    typedef enum logic [1:0] {IDLE, COUNT, WR_CODE, WR_CNT} stateE;

    stateE state;
    logic [1:0] trigSync;           // Two-flop synchronizer
    logic trigDly;                  // Edge detect
    logic trigFall;
    dacCodeT stepCode;              // Code on the swept DAC
    dacCodeT endCode;
    dacCodeT winLen;
    dacCodeT winCnt;
    logic [1:0] selLat;
    logic [`CNT_WIDTH-1:0] evtCnt;
    logic stopPend;                 // Stopped with a count still owed
    logic stopNow;
    logic nextStep;
    logic stepping;

    //////////////////////////////////////////////////////////////////////
    // Trigger input
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            trigSync <= 2'b11;  // Line idles high
            trigDly <= 1'b1;
        end else begin
            trigSync <= {trigSync[0], outTrigN};
            trigDly <= trigSync[1];
        end
    end

    assign trigFall = trigDly & ~trigSync[1];

    assign stopNow = cfg.stop & cfg.busy;
    assign nextStep = (state == WR_CNT) && !full && !stopPend && !stopNow &&
                      (stepCode != endCode);
    assign stepping = cfg.busy && (state != IDLE);

    // Code word goes out first, then the count
    assign wrEn = ((state == WR_CODE) || (state == WR_CNT)) && !full;
    assign wrData = (state == WR_CODE) ? dataWordT'(stepCode) : dataWordT'(evtCnt);

    // Swept DAC shows the step code, the rest follow their registers
    assign dac0Out = (stepping && selLat == 2'd0) ? stepCode : dac0Reg;
    assign dac1Out = (stepping && selLat == 2'd1) ? stepCode : dac1Reg;
    assign dac2Out = (stepping && selLat == 2'd2) ? stepCode : dac2Reg;

    // Settings latched at start
    always_ff @(posedge Clk) begin
        if (state == IDLE && cfg.start) begin
            stepCode <= cfg.startDac;
            endCode <= cfg.endDac;
            winLen <= cfg.window;
            selLat <= cfg.dacSel;
        end else if (nextStep) begin
            stepCode <= stepCode + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= IDLE;
            cfg.busy <= 1'b0;
            sweepDone <= 1'b0;
            stopPend <= 1'b0;
            winCnt <= '0;
            evtCnt <= '0;
        end else if (stopNow) begin
            cfg.busy <= 1'b0;  // No done flag on stop
            if (state == WR_CODE && !full) begin
                state <= WR_CNT;  // Code goes out this cycle, count owed
                stopPend <= 1'b1;
            end else if (state == WR_CNT && full) begin
                stopPend <= 1'b1;  // Hold until the owed count fits
            end else begin
                state <= IDLE;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (cfg.start) begin
                        cfg.busy <= 1'b1;
                        sweepDone <= 1'b0;
                        stopPend <= 1'b0;
                        winCnt <= '0;
                        evtCnt <= '0;
                        if (cfg.startDac <= cfg.endDac)
                            state <= COUNT;
                    end else if (cfg.busy) begin
                        cfg.busy <= 1'b0;  // Empty range ends here
                        sweepDone <= 1'b1;
                    end
                end
                COUNT: begin
                    if (trigFall && evtCnt != '1)
                        evtCnt <= evtCnt + 1'b1;  // Saturates
                    winCnt <= winCnt + 1'b1;
                    if (winCnt == winLen - 1'b1)
                        state <= WR_CODE;
                end
                WR_CODE: begin
                    if (!full)
                        state <= WR_CNT;
                end
                WR_CNT: begin
                    if (nextStep) begin
                        winCnt <= '0;
                        evtCnt <= '0;
                        state <= COUNT;
                    end else if (!full) begin
                        state <= IDLE;
                        stopPend <= 1'b0;
                        if (!stopPend) begin
                            cfg.busy <= 1'b0;  // End code written
                            sweepDone <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Window counter stays inside the latched window
    assert property (@(posedge Clk) disable iff (!rstN) state == COUNT |-> winCnt < winLen)
        else $error("Window counter ran past the window length");

endmodule

`default_nettype wire

// File: design/dataFifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "daqDefines.svh"

module dataFifo import daqPkg::*; (
    input wire Clk,
    input wire rstN,
    input wire wrEn,
    input wire dataWordT wrData,
    output logic full,
    input wire rdEn,
    output dataWordT rdData,
    output logic empty
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    dataWordT mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0] count;  // Occupancy, 0 to depth
    logic doWr;
    logic doRd;

    assign full = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign empty = (count == '0);
    assign doWr = wrEn & ~full;
    assign doRd = rdEn & ~empty;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWr)
                wrPtr <= wrPtr + 1'b1;
            if (doRd)
                rdPtr <= rdPtr + 1'b1;
            case ({doWr, doRd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (doWr)
            mem[wrPtr] <= wrData;
        if (doRd)
            rdData <= mem[rdPtr];  // Valid the cycle after rdEn
    end

    // Host side must respect empty
    assert property (@(posedge Clk) disable iff (!rstN) rdEn |-> !empty)
        else $error("Read from empty result FIFO");

endmodule

`default_nettype wire

// File: design/daqTop.sv
`timescale 1ns/100ps
`default_nettype none

module daqTop import daqPkg::*; (
    input wire Clk,
    input wire rstN,
    // Command FIFO
    input wire cmdEmpty,
    input wire dataWordT cmdWord,
    output wire cmdRdEn,
    // ASIC trigger, async and active low
    input wire outTrigN,
    // Threshold DACs
    output wire dacCodeT dac0Out,
    output wire dacCodeT dac1Out,
    output wire dacCodeT dac2Out,
    // Status
    output wire sweepBusy,
    output wire sweepDone,
    // Result FIFO, host reads
    input wire dataRdEn,
    output wire dataEmpty,
    output wire dataWordT dataOut
);

    wire dacCodeT dac0Reg;
    wire dacCodeT dac1Reg;
    wire dacCodeT dac2Reg;
    wire fifoWrEn;
    wire dataWordT fifoWrData;
    wire fifoFull;

    sweepCfgIf cfgBus ();

    assign sweepBusy = cfgBus.busy;

    commandInterpreter u_cmd (
        .Clk(Clk),
        .rstN(rstN),
        .cmdEmpty(cmdEmpty),
        .cmdRdEn(cmdRdEn),
        .cmdWord(cmdWord),
        .cfg(cfgBus.cfg),
        .dac0Reg(dac0Reg),
        .dac1Reg(dac1Reg),
        .dac2Reg(dac2Reg)
    );

    sweepController u_sweep (
        .Clk(Clk),
        .rstN(rstN),
        .cfg(cfgBus.ctrl),
        .dac0Reg(dac0Reg),
        .dac1Reg(dac1Reg),
        .dac2Reg(dac2Reg),
        .outTrigN(outTrigN),
        .dac0Out(dac0Out),
        .dac1Out(dac1Out),
        .dac2Out(dac2Out),
        .sweepDone(sweepDone),
        .wrEn(fifoWrEn),
        .wrData(fifoWrData),
        .full(fifoFull)
    );

    dataFifo u_fifo (
        .Clk(Clk),
        .rstN(rstN),
        .wrEn(fifoWrEn),
        .wrData(fifoWrData),
        .full(fifoFull),
        .rdEn(dataRdEn),
        .rdData(dataOut),
        .empty(dataEmpty)
    );

endmodule

`default_nettype wire

// File: bench/daqTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "daqDefines.svh"

module daqTb;

    localparam int maxCycles = 20000;  // Whole run needs a few thousand
    localparam int addrStart = 3;
    localparam int addrEnd = 4;
    localparam int addrWindow = 5;
    localparam int addrSel = 6;
    localparam int opStart = 1;
    localparam int opStop = 2;

    logic Clk;
    logic rstN;
    logic cmdEmpty;
    logic [`WORD_WIDTH-1:0] cmdWord;
    wire cmdRdEn;
    logic outTrigN;
    wire [`DAC_WIDTH-1:0] dac0Out;
    wire [`DAC_WIDTH-1:0] dac1Out;
    wire [`DAC_WIDTH-1:0] dac2Out;
    wire sweepBusy;
    wire sweepDone;
    logic dataRdEn;
    wire dataEmpty;
    wire [`WORD_WIDTH-1:0] dataOut;

    integer seed;
    int cycleCnt = 0;
    logic popPend = 1'b0;             // Command FIFO read seen last cycle
    logic trigOn;                     // Trigger driver armed
    int curStart;                     // Settings of the running sweep
    int curSel;
    int stepIdx;
    int regVal [3];                   // DAC0..DAC2 register model
    logic [`WORD_WIDTH-1:0] cmdQ [$];  // Command FIFO contents
    int cntQ [$];                     // Pulses per step, drawn up front
    int expQ [$];                     // Expected code, count, code, ...
    logic [31:0] gotQ [$];

    daqTop i_dut (
        .Clk(Clk),
        .rstN(rstN),
        .cmdEmpty(cmdEmpty),
        .cmdWord(cmdWord),
        .cmdRdEn(cmdRdEn),
        .outTrigN(outTrigN),
        .dac0Out(dac0Out),
        .dac1Out(dac1Out),
        .dac2Out(dac2Out),
        .sweepBusy(sweepBusy),
        .sweepDone(sweepDone),
        .dataRdEn(dataRdEn),
        .dataEmpty(dataEmpty),
        .dataOut(dataOut)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Hang guard
    always @(posedge Clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= maxCycles) begin
            $display("Run did not finish within %0d cycles, DUT appears hung", maxCycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    // Command FIFO model, pops on the cycle after cmdRdEn
    always @(negedge Clk) begin
        if (rstN && cmdRdEn) begin
            checkEq("cmdRdEn while cmdEmpty", 0, cmdEmpty);
            checkEq("cmdRdEn back to back", 0, popPend);
        end
        if (popPend)
            cmdWord = cmdQ.pop_front();
        popPend = cmdRdEn;
        cmdEmpty = (cmdQ.size() == 0);
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic checkEq(input string name, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic int randRange(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Address, 2 reserved bits, 10-bit value
    function automatic logic [15:0] regWord(input int addr, input int val);
        return {addr[3:0], 2'b00, val[9:0]};
    endfunction

    function automatic logic [15:0] actWord(input int op);
        return {4'hf, op[3:0], 8'h00};  // ACTION address
    endfunction

    function automatic logic [`DAC_WIDTH-1:0] sweptDac();
        case (curSel)
            0: return dac0Out;
            1: return dac1Out;
            default: return dac2Out;
        endcase
    endfunction

    // Unswept outputs show their registers, sel 3 checks all
    task automatic checkDacs(input int swept);
        if (swept != 0)
            checkEq("dac0Out", regVal[0], dac0Out);
        if (swept != 1)
            checkEq("dac1Out", regVal[1], dac1Out);
        if (swept != 2)
            checkEq("dac2Out", regVal[2], dac2Out);
    endtask

    task automatic flushCmds();
        while (cmdQ.size() != 0 || popPend || cmdRdEn)
            @(negedge Clk);
        repeat (4) @(negedge Clk);  // Decode plus start or stop pulse
    endtask

    task automatic startSweep(input int first, input int last, input int win,
                              input int sel);
        curStart = first;
        curSel = sel;
        stepIdx = 0;
        expQ.delete();
        cntQ.delete();
        for (int i = first; i <= last; i++)
            cntQ.push_back(randRange(0, (win - 8) / 4));
        trigOn = (first <= last);
        cmdQ.push_back(regWord(addrStart, first));
        cmdQ.push_back(regWord(addrEnd, last));
        cmdQ.push_back(regWord(addrWindow, win));
        cmdQ.push_back(regWord(addrSel, sel));
        cmdQ.push_back(actWord(opStart));
        flushCmds();
    endtask

    // Host reader with random stalls, runs until the sweep is over and drained
    task automatic readResults(input int stallPct);
        logic rdPend;
        rdPend = 1'b0;
        gotQ.delete();
        while (sweepBusy || !dataEmpty || rdPend) begin
            if (rdPend)
                gotQ.push_back(dataOut);  // Valid one cycle after dataRdEn
            rdPend = !dataEmpty && (randRange(0, 99) >= stallPct);
            dataRdEn = rdPend;
            @(negedge Clk);
        end
    endtask

    task automatic compareWords(input bit prefixOnly);
        if (prefixOnly) begin
            checkEq("result word count parity", 0, gotQ.size() % 2);
            checkEq("result words within model", 1, gotQ.size() <= expQ.size());
        end else begin
            checkEq("result word count", expQ.size(), gotQ.size());
        end
        foreach (gotQ[i])
            checkEq($sformatf("dataOut word %0d", i), expQ[i], gotQ[i]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Trigger driver
    // Step start seen as busy rising or the swept output moving
    //////////////////////////////////////////////////////////////////////
    initial begin : trigDriver
        logic [`DAC_WIDTH-1:0] prevOut;
        logic prevBusy;
        int n;
        prevOut = '0;
        prevBusy = 1'b0;
        forever begin
            @(negedge Clk);
            if (trigOn && sweepBusy && (!prevBusy || sweptDac() != prevOut)) begin
                checkEq("swept DAC step code", curStart + stepIdx, sweptDac());
                checkDacs(curSel);
                n = cntQ.pop_front();
                expQ.push_back(curStart + stepIdx);
                expQ.push_back(n);
                stepIdx++;
                repeat (4) @(negedge Clk);  // Leading margin
                repeat (n) begin
                    outTrigN = 1'b0;  // One-cycle low pulse
                    @(negedge Clk);
                    outTrigN = 1'b1;
                    repeat (3) @(negedge Clk);
                end
            end
            prevOut = sweptDac();
            prevBusy = sweepBusy;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : mainSeq
        int first;
        seed = 32'hc9e1_baea;
        rstN = 1'b0;
        cmdEmpty = 1'b1;
        cmdWord = '0;
        outTrigN = 1'b1;
        dataRdEn = 1'b0;
        trigOn = 1'b0;
        curSel = 0;
        foreach (regVal[i])
            regVal[i] = 0;
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
        @(negedge Clk);

        // Reset state
        checkEq("cmdRdEn", 0, cmdRdEn);
        checkEq("sweepBusy", 0, sweepBusy);
        checkEq("sweepDone", 0, sweepDone);
        checkEq("dataEmpty", 1, dataEmpty);
        checkDacs(3);

        // Threshold writes, then junk that must change nothing
        for (int i = 0; i < 3; i++) begin
            regVal[i] = randRange(0, 1023);
            cmdQ.push_back(regWord(i, regVal[i]));
        end
        cmdQ.push_back(regWord(randRange(7, 14), randRange(0, 1023)));  // Unknown address
        cmdQ.push_back(actWord(randRange(3, 15)));                       // Unknown opcode
        cmdQ.push_back(actWord(0));
        flushCmds();
        checkDacs(3);
        checkEq("sweepBusy", 0, sweepBusy);
        checkEq("dataEmpty", 1, dataEmpty);

        // Random full sweeps
        repeat (3) begin
            first = randRange(0, 1000);
            startSweep(first, first + randRange(0, 5), randRange(40, 80), randRange(0, 2));
            readResults(30);
            compareWords(1'b0);
            checkEq("sweepDone", 1, sweepDone);
            checkDacs(3);
        end

        // Start above end
        first = randRange(10, 1000);
        startSweep(first, first - randRange(1, 9), 40, randRange(0, 2));
        checkEq("sweepBusy", 0, sweepBusy);
        checkEq("sweepDone", 1, sweepDone);
        repeat (20) @(negedge Clk);
        checkEq("dataEmpty", 1, dataEmpty);

        // Back-pressure, 8 pairs fill the FIFO in about 340 cycles
        first = randRange(0, 900);
        startSweep(first, first + randRange(9, 11), 40, randRange(0, 2));
        repeat (450) @(negedge Clk);
        checkEq("result FIFO full", 1, i_dut.fifoFull);
        checkEq("sweepBusy while stalled", 1, sweepBusy);
        readResults(50);
        compareWords(1'b0);
        checkEq("sweepDone", 1, sweepDone);

        // Stop during the second step
        first = randRange(0, 990);
        startSweep(first, first + 5, 60, randRange(0, 2));
        while (stepIdx < 2)
            @(negedge Clk);
        cmdQ.push_back(actWord(opStop));
        flushCmds();
        checkEq("sweepBusy after stop", 0, sweepBusy);
        checkEq("sweepDone after stop", 0, sweepDone);
        trigOn = 1'b0;
        readResults(30);
        compareWords(1'b1);
        checkEq("words before stop", 1, gotQ.size() >= 2);
        checkDacs(3);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/daqPkg.sv
design/sweepCfgIf.sv
design/commandInterpreter.sv
design/sweepController.sv
design/dataFifo.sv
design/daqTop.sv
bench/daqTb.sv

// File: Bender.yml
package:
  name: daqSweep

sources:
  - include_dirs:
      - design
    files:
      - design/daqPkg.sv
      - design/sweepCfgIf.sv
      - design/commandInterpreter.sv
      - design/sweepController.sv
      - design/dataFifo.sv
      - design/daqTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/daqTb.sv
